/* rtl/clk_cfg.svh */
/*
 * Clock control unit configuration
 * Register offsets, divider sizing and build options
 */
`ifndef CLK_CFG_SVH
`define CLK_CFG_SVH

// ==================================================
// Divider
// ==================================================

// Width of the divide ratio field
`define CLK_DIV_W 5

// Input cycles from a ratio load to lock
`define CLK_LOCK_CYCLES 16

// Nonzero builds the divider and the divided source
`define CLK_HAS_DIV 1

// ==================================================
// APB register map, byte offsets
// ==================================================
`define CLK_REG_CTRL   4'h0
`define CLK_REG_DIV    4'h4
`define CLK_REG_STATUS 4'h8

`endif

/* rtl/clk_pkg.sv */
/*
 * Clock control unit types
 * Source select, control and status words, APB request and response
 */
`include "clk_cfg.svh"

package clk_pkg;

    // Clock source select
    // Encoding doubles as the index of the source in the switch
    typedef enum logic [1:0] {
        SRC_REF = 2'd0,
        SRC_DIV = 2'd1,
        SRC_OFF = 2'd2
    } clk_src_e;

    // Switch sequencer states
    typedef enum logic [1:0] {
        SW_IDLE  = 2'd0,
        SW_DROP  = 2'd1,
        SW_RAISE = 2'd2
    } clk_sw_state_e;

    // Control word from the register block
    typedef struct packed {
        clk_src_e              src;
        logic                  sys_en;
        logic                  off_en;
        logic [`CLK_DIV_W-1:0] ratio;
    } clk_ctrl_t;

    // Live status back to the register block
    typedef struct packed {
        logic     lock;
        clk_src_e active;
        logic     busy;
    } clk_status_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

/* rtl/clk_apb_regs.sv */
/*
 * APB register block of the clock control unit
 * CTRL and DIV are read/write, STATUS is read-only and live
 */
`timescale 1ns/1ps
`include "clk_cfg.svh"

module clk_apb_regs (
    input  logic                 ref_clk,
    input  logic                 rst,
    input  clk_pkg::apb_req_t    apb_req,
    output clk_pkg::apb_rsp_t    apb_rsp,
    input  clk_pkg::clk_status_t status,
    output clk_pkg::clk_ctrl_t   ctrl
);

    localparam int DIV_W = `CLK_DIV_W;

    // Stored fields
    clk_pkg::clk_src_e src_q;
    logic              sys_en_q;
    logic              off_en_q;
    logic [DIV_W-1:0]  ratio_q;

    // Decode
    logic              access;
    logic              hit_ctrl;
    logic              hit_div;
    logic              hit_status;
    logic              bad_addr;
    logic              fault;
    logic              do_write;

    // Write data after cleanup
    clk_pkg::clk_src_e wr_src;
    logic [DIV_W-1:0]  wr_ratio;

    logic [31:0]       rdata;

    // ==================================================
    // Address decode
    // ==================================================

    // Access phase only, pready is tied high
    assign access     = apb_req.psel && apb_req.penable;
    assign hit_ctrl   = (apb_req.paddr == `CLK_REG_CTRL);
    assign hit_div    = (apb_req.paddr == `CLK_REG_DIV);
    assign hit_status = (apb_req.paddr == `CLK_REG_STATUS);
    assign bad_addr   = !(hit_ctrl || hit_div || hit_status);

    // Unmapped offset or write to STATUS
    assign fault    = access && (bad_addr || (apb_req.pwrite && hit_status));
    // Faulted writes are dropped
    assign do_write = access && apb_req.pwrite && !fault;

    // Zero ratio would stall the divider, store 1
    assign wr_ratio = (apb_req.pwdata[DIV_W-1:0] == '0) ? DIV_W'(1)
                                                       : apb_req.pwdata[DIV_W-1:0];

    // Unused code 3 selects the reference
    always_comb begin
        case (apb_req.pwdata[1:0])
            2'd1:    wr_src = clk_pkg::SRC_DIV;
            2'd2:    wr_src = clk_pkg::SRC_OFF;
            default: wr_src = clk_pkg::SRC_REF;
        endcase
    end

    // ==================================================
    // Registers
    // ==================================================
    always_ff @(posedge ref_clk) begin
        if (rst) begin
            src_q    <= clk_pkg::SRC_REF;
            sys_en_q <= 1'b1;
            off_en_q <= 1'b1;
            ratio_q  <= DIV_W'(1);
        end else if (do_write) begin
            if (hit_ctrl) begin
                src_q    <= wr_src;
                sys_en_q <= apb_req.pwdata[4];
                off_en_q <= apb_req.pwdata[5];
            end
            if (hit_div) begin
                ratio_q <= wr_ratio;
            end
        end
    end

    // Read mux, STATUS straight from the live inputs
    always_comb begin
        rdata = '0;
        if (hit_ctrl) begin
            rdata[1:0] = src_q;
            rdata[4]   = sys_en_q;
            rdata[5]   = off_en_q;
        end else if (hit_div) begin
            rdata[DIV_W-1:0] = ratio_q;
        end else if (hit_status) begin
            rdata[0]   = status.lock;
            rdata[5:4] = status.active;
            rdata[8]   = status.busy;
        end
    end

    // Bus quiet outside read access phases
    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = fault;

    // Control word out
    assign ctrl.src    = src_q;
    assign ctrl.sys_en = sys_en_q;
    assign ctrl.off_en = off_en_q;
    assign ctrl.ratio  = ratio_q;

endmodule

/* rtl/clk_div_gen.sv */
/*
 * Programmable clock divider, stands in for the PLL
 * Half period of ratio input cycles, lock after a settling count
 */
`timescale 1ns/1ps
`include "clk_cfg.svh"

module clk_div_gen (
    input  logic                  clk_in,
    input  logic                  rst,
    input  logic [`CLK_DIV_W-1:0] ratio,
    output logic                  clk_out,
    output logic                  lock
);

    localparam int DIV_W       = `CLK_DIV_W;
    localparam int LOCK_CYCLES = `CLK_LOCK_CYCLES;
    localparam int SETTLE_W    = $clog2(LOCK_CYCLES);

    // Period generation
    logic [DIV_W-1:0]    half_cnt;
    logic [DIV_W:0]      half_next;
    logic [DIV_W-1:0]    ratio_q;
    logic                half_end;
    logic                period_end;
    logic                clk_q;

    // Lock tracking
    logic [DIV_W-1:0]    ratio_seen;
    logic                pending;
    logic [SETTLE_W-1:0] settle_cnt;
    logic                lock_q;

    // One extra bit, a zero ratio ends every cycle
    assign half_next  = {1'b0, half_cnt} + 1'b1;
    assign half_end   = (half_next >= {1'b0, ratio_q});
    // End of the low half, next cycle starts a full period
    assign period_end = half_end && !clk_q;

    // ==================================================
    // Half-period counter
    // ==================================================
    always_ff @(posedge clk_in) begin
        if (rst) begin
            half_cnt <= '0;
            ratio_q  <= DIV_W'(1);
            clk_q    <= 1'b0;
        end else if (half_end) begin
            half_cnt <= '0;
            clk_q    <= ~clk_q;
            // New ratio only at a full period boundary
            if (!clk_q) begin
                ratio_q <= ratio;
            end
        end else begin
            half_cnt <= half_next[DIV_W-1:0];
        end
    end

    // ==================================================
    // Settling and lock
    // ==================================================
    always_ff @(posedge clk_in) begin
        if (rst) begin
            ratio_seen <= '0;
            pending    <= 1'b1;
            settle_cnt <= '0;
            lock_q     <= 1'b0;
        end else begin
            ratio_seen <= ratio;
            if (ratio != ratio_seen) begin
                // Ratio moved, wait for the reload
                pending    <= 1'b1;
                settle_cnt <= '0;
                lock_q     <= 1'b0;
            end else if (pending) begin
                if (period_end) begin
                    pending <= 1'b0;
                end
            end else if (!lock_q) begin
                if (settle_cnt == SETTLE_W'(LOCK_CYCLES - 1)) begin
                    lock_q <= 1'b1;
                end else begin
                    settle_cnt <= settle_cnt + 1'b1;
                end
            end
        end
    end

    assign clk_out = clk_q;
    assign lock    = lock_q;

endmodule

/* rtl/clk_src_mux.sv */
/*
 * Glitch-free three-way clock switch
 * Break-before-make, one enable synchronizer per source
 */
`timescale 1ns/1ps
`include "clk_cfg.svh"

module clk_src_mux (
    input  logic              ref_clk,
    input  logic              div_clk,
    input  logic              off_clk,
    input  logic              rst,
    input  clk_pkg::clk_src_e sel,
    output logic              clk_out,
    output clk_pkg::clk_src_e active,
    output logic              busy
);

    localparam bit HAS_DIV = (`CLK_HAS_DIV != 0);
    localparam int N_SRC   = 3;

    logic [N_SRC-1:0]       src_clk;
    // Enable requests, ref_clk domain
    logic [N_SRC-1:0]       req_en;
    // Enables seen by each source on its own clock
    logic [N_SRC-1:0]       gate_en;
    // gate_en brought back to ref_clk
    logic [N_SRC-1:0]       ack;

    clk_pkg::clk_src_e      want;
    clk_pkg::clk_src_e      active_q;
    clk_pkg::clk_src_e      target_q;
    clk_pkg::clk_sw_state_e state_q;

    // Bit order follows the clk_src_e encoding
    assign src_clk = {off_clk, div_clk, ref_clk};

    // ==================================================
    // Per-source synchronizers
    // ==================================================
    for (genvar i = 0; i < N_SRC; i++) begin : g_src
        logic [1:0] en_sync;
        logic [1:0] ack_sync;

        // Falling edge, gate only moves while its clock is low
        always_ff @(negedge src_clk[i]) begin
            if (rst) begin
                en_sync <= (i == 0) ? 2'b11 : 2'b00;
            end else begin
                en_sync <= {en_sync[0], req_en[i]};
            end
        end

        assign gate_en[i] = en_sync[1];

        // Feedback for the sequencer
        always_ff @(posedge ref_clk) begin
            if (rst) begin
                ack_sync <= (i == 0) ? 2'b11 : 2'b00;
            end else begin
                ack_sync <= {ack_sync[0], gate_en[i]};
            end
        end

        assign ack[i] = ack_sync[1];
    end

    // Divided source missing falls back to ref
    always_comb begin
        case (sel)
            clk_pkg::SRC_DIV: want = HAS_DIV ? clk_pkg::SRC_DIV : clk_pkg::SRC_REF;
            clk_pkg::SRC_OFF: want = clk_pkg::SRC_OFF;
            default:          want = clk_pkg::SRC_REF;
        endcase
    end

    // ==================================================
    // Switch sequencer, ref_clk domain
    // ==================================================
    always_ff @(posedge ref_clk) begin
        if (rst) begin
            state_q  <= clk_pkg::SW_IDLE;
            active_q <= clk_pkg::SRC_REF;
            target_q <= clk_pkg::SRC_REF;
            req_en   <= 3'b001;
        end else begin
            case (state_q)
                // Requests only sampled here, later ones wait
                clk_pkg::SW_IDLE: begin
                    if (want != active_q) begin
                        req_en[active_q] <= 1'b0;
                        target_q         <= want;
                        state_q          <= clk_pkg::SW_DROP;
                    end
                end
                // Old gate must be closed before the new one opens
                clk_pkg::SW_DROP: begin
                    if (!ack[active_q]) begin
                        req_en[target_q] <= 1'b1;
                        state_q          <= clk_pkg::SW_RAISE;
                    end
                end
                clk_pkg::SW_RAISE: begin
                    if (ack[target_q]) begin
                        active_q <= target_q;
                        state_q  <= clk_pkg::SW_IDLE;
                    end
                end
                default: state_q <= clk_pkg::SW_IDLE;
            endcase
        end
    end

    // At most one enable high at a time
    assign clk_out = |(src_clk & gate_en);
    assign active  = active_q;
    assign busy    = (state_q != clk_pkg::SW_IDLE);

endmodule

/* rtl/clk_release_gate.sv */
/*
 * Glitch-free releasable clock gate
 * Enable synchronized on rising edges, applied in the low phase
 */
`timescale 1ns/1ps

module clk_release_gate (
    input  logic clk_in,
    input  logic rst,
    input  logic en,
    output logic clk_out
);

    // Two-stage synchronizer, enable may come from another domain
    logic [1:0] en_sync;
    // Enable held across the high phase
    logic       en_lat;

    // ==================================================
    // Enable path
    // ==================================================

    // Gate open after reset
    always_ff @(posedge clk_in) begin
        if (rst) begin
            en_sync <= 2'b11;
        end else begin
            en_sync <= {en_sync[0], en};
        end
    end

    // Update while the clock is low
    // so the high phase is never cut short
    always_ff @(negedge clk_in) begin
        if (rst) begin
            en_lat <= 1'b1;
        end else begin
            en_lat <= en_sync[1];
        end
    end

    // Stopped output sits low
    assign clk_out = clk_in & en_lat;

endmodule

/* rtl/clk_ctrl_top.sv */
/*
 * Clock control unit top
 * Registers, divider, source switch and two output gates
 */
`timescale 1ns/1ps
`include "clk_cfg.svh"

module clk_ctrl_top (
    input  logic              ref_clk,
    input  logic              off_clk,
    input  logic              rst,
    input  clk_pkg::apb_req_t apb_req,
    output clk_pkg::apb_rsp_t apb_rsp,
    output logic              sys_clk,
    output logic              off_clk_gated
);

    clk_pkg::clk_ctrl_t   ctrl;
    clk_pkg::clk_status_t status;
    clk_pkg::clk_src_e    active;
    logic                 busy;
    logic                 div_clk;
    logic                 div_lock;
    // Switch output ahead of the system gate
    logic                 mux_clk;

    // ==================================================
    // Register block, ref_clk domain
    // ==================================================
    clk_apb_regs regs_i (
        .ref_clk (ref_clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .status  (status),
        .ctrl    (ctrl)
    );

    assign status.lock   = div_lock;
    assign status.active = active;
    assign status.busy   = busy;

    // Divided source, built only when configured
    if (`CLK_HAS_DIV != 0) begin : g_div
        clk_div_gen div_i (
            .clk_in  (ref_clk),
            .rst     (rst),
            .ratio   (ctrl.ratio),
            .clk_out (div_clk),
            .lock    (div_lock)
        );
    end else begin : g_no_div
        assign div_clk  = 1'b0;
        assign div_lock = 1'b0;
    end

    clk_src_mux mux_i (
        .ref_clk (ref_clk),
        .div_clk (div_clk),
        .off_clk (off_clk),
        .rst     (rst),
        .sel     (ctrl.src),
        .clk_out (mux_clk),
        .active  (active),
        .busy    (busy)
    );

    // ==================================================
    // Output gates
    // ==================================================
    clk_release_gate sys_gate_i (
        .clk_in  (mux_clk),
        .rst     (rst),
        .en      (ctrl.sys_en),
        .clk_out (sys_clk)
    );

    clk_release_gate off_gate_i (
        .clk_in  (off_clk),
        .rst     (rst),
        .en      (ctrl.off_en),
        .clk_out (off_clk_gated)
    );

endmodule

/* test/tb_clk_ctrl.sv */
/*
 * Testbench for the clock control unit
 * APB register access, divider lock and rate, source switching, output gates
 */
`timescale 1ns/1ps
`include "clk_cfg.svh"

module tb_clk_ctrl;

    localparam int          REF_PERIOD    = 20;
    localparam int          OFF_PERIOD    = 30;
    // Edge count window in ref_clk cycles
    localparam int          WINDOW        = 480;
    localparam int          POLL_LIMIT    = 400;
    localparam int          SAMPLE_DELAY  = 5;
    // Two rising edges plus a low phase of the slower clock plus margin
    localparam int          GATE_SETTLE   = 8;
    localparam int unsigned SEED          = 32'h4d0e_d6b2;
    // Shortest legal phase is the half period of the fastest source
    localparam realtime     SYS_MIN_PHASE = 10.0;
    localparam realtime     OFF_MIN_PHASE = 15.0;

    logic              ref_clk;
    logic              off_clk;
    logic              rst;
    clk_pkg::apb_req_t apb_req;
    clk_pkg::apb_rsp_t apb_rsp;
    logic              sys_clk;
    logic              off_clk_gated;

    int                errors    = 0;
    int                checks    = 0;
    int                sys_edges = 0;
    int                off_edges = 0;
    int                sys_short = 0;
    int                off_short = 0;
    realtime           sys_last  = -1.0;
    realtime           off_last  = -1.0;
    bit                mon_on    = 1'b0;

    clk_ctrl_top dut_i (
        .ref_clk       (ref_clk),
        .off_clk       (off_clk),
        .rst           (rst),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .sys_clk       (sys_clk),
        .off_clk_gated (off_clk_gated)
    );

    // ==================================================
    // Clocks and output monitors
    // ==================================================
    always #(REF_PERIOD / 2) ref_clk = ~ref_clk;
    always #(OFF_PERIOD / 2) off_clk = ~off_clk;

    always @(posedge sys_clk) sys_edges++;
    always @(posedge off_clk_gated) off_edges++;

    // Any phase below the fastest source half period is a glitch
    always @(sys_clk) begin
        if (mon_on) begin
            if (sys_last >= 0.0 && ($realtime - sys_last) < SYS_MIN_PHASE) begin
                sys_short++;
                $display("ERROR: sys_clk phase of %0.3f ns ending at %0t ns is too short",
                         $realtime - sys_last, $time);
            end
            sys_last = $realtime;
        end
    end

    always @(off_clk_gated) begin
        if (mon_on) begin
            if (off_last >= 0.0 && ($realtime - off_last) < OFF_MIN_PHASE) begin
                off_short++;
                $display("ERROR: off_clk_gated phase of %0.3f ns ending at %0t ns is too short",
                         $realtime - off_last, $time);
            end
            off_last = $realtime;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================

    // Equal within tol, unknown bits never match
    task automatic check_value(input string name, input logic signed [63:0] actual,
                               input logic signed [63:0] expected, input int tol);
        longint diff;
        diff = 0;
        if (!$isunknown(actual)) begin
            diff = actual - expected;
            if (diff < 0) begin
                diff = -diff;
            end
        end
        checks++;
        if ($isunknown(actual) || diff > tol) begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    // Source in bits 1:0, sys enable in bit 4, offload enable in bit 5
    function automatic logic [31:0] ctrl_word(input clk_pkg::clk_src_e src,
                                              input logic sys_en, input logic off_en);
        logic [31:0] w;
        w      = '0;
        w[1:0] = src;
        w[4]   = sys_en;
        w[5]   = off_en;
        return w;
    endfunction

    // Rising edges expected in one window
    function automatic int expected_edges(input clk_pkg::clk_src_e src, input int ratio);
        case (src)
            clk_pkg::SRC_DIV: return WINDOW / (2 * ratio);
            clk_pkg::SRC_OFF: return WINDOW * REF_PERIOD / OFF_PERIOD;
            default:          return WINDOW;
        endcase
    endfunction

    // Setup phase, then access phase held until pready
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        @(negedge ref_clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge ref_clk);
        apb_req.penable = 1'b1;
        // Sample mid low phase well clear of both edges
        #(SAMPLE_DELAY);
        while (apb_rsp.pready !== 1'b1 && waited < POLL_LIMIT) begin
            @(negedge ref_clk);
            #(SAMPLE_DELAY);
            waited++;
        end
        if (apb_rsp.pready !== 1'b1) begin
            errors++;
            $display("ERROR: APB access to offset 0x%0h never saw pready", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge ref_clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_value($sformatf("pslverr on write to 0x%0h", addr), err, exp_err, 0);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_value($sformatf("pslverr on read of 0x%0h", addr), err, exp_err, 0);
    endtask

    task automatic wait_lock();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[0] && polls < POLL_LIMIT) begin
            apb_read(`CLK_REG_STATUS, st, 1'b0);
            polls++;
        end
        if (!st[0]) begin
            errors++;
            $display("ERROR: divider lock did not come up within %0d status reads",
                     POLL_LIMIT);
        end
    endtask

    // Waits for idle on the requested source so a queued switch is not missed
    task automatic wait_not_busy(input clk_pkg::clk_src_e want);
        logic [31:0] st;
        int          polls;
        st    = 32'h100;
        polls = 0;
        while ((st[8] || st[5:4] != want) && polls < POLL_LIMIT) begin
            apb_read(`CLK_REG_STATUS, st, 1'b0);
            polls++;
        end
        if (st[8] || st[5:4] != want) begin
            errors++;
            $display("ERROR: switch to source %0d did not finish within %0d status reads",
                     want, POLL_LIMIT);
        end
    endtask

    task automatic count_edges(input bit use_off, output int edges);
        int start;
        @(negedge ref_clk);
        start = use_off ? off_edges : sys_edges;
        repeat (WINDOW) @(negedge ref_clk);
        edges = (use_off ? off_edges : sys_edges) - start;
    endtask

    task automatic switch_and_measure(input clk_pkg::clk_src_e src, input int ratio);
        logic [31:0] st;
        int          edges;
        apb_write(`CLK_REG_CTRL, ctrl_word(src, 1'b1, 1'b1), 1'b0);
        wait_not_busy(src);
        apb_read(`CLK_REG_STATUS, st, 1'b0);
        check_value("STATUS busy", st[8], 0, 0);
        check_value("STATUS active", st[5:4], src, 0);
        count_edges(1'b0, edges);
        check_value($sformatf("sys_clk edges from source %0d", src), edges,
                    expected_edges(src, ratio), 1);
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic register_access();
        logic [31:0] rd;
        apb_read(`CLK_REG_CTRL, rd, 1'b0);
        check_value("CTRL after reset", rd, 32'h30, 0);
        apb_read(`CLK_REG_DIV, rd, 1'b0);
        check_value("DIV after reset", rd, 1, 0);
        apb_read(`CLK_REG_STATUS, rd, 1'b0);
        check_value("STATUS active after reset", rd[5:4], clk_pkg::SRC_REF, 0);
        check_value("STATUS busy after reset", rd[8], 0, 0);
        apb_write(`CLK_REG_DIV, 32'd5, 1'b0);
        apb_read(`CLK_REG_DIV, rd, 1'b0);
        check_value("DIV readback", rd, 5, 0);
        // Zero ratio clamps to one
        apb_write(`CLK_REG_DIV, 32'd0, 1'b0);
        apb_read(`CLK_REG_DIV, rd, 1'b0);
        check_value("DIV zero ratio", rd, 1, 0);
        apb_write(`CLK_REG_CTRL, ctrl_word(clk_pkg::SRC_REF, 1'b0, 1'b1), 1'b0);
        apb_read(`CLK_REG_CTRL, rd, 1'b0);
        check_value("CTRL readback", rd, 32'h20, 0);
        // Faulted accesses leave the registers alone
        apb_write(4'hC, 32'hFFFF_FFFF, 1'b1);
        apb_read(4'hC, rd, 1'b1);
        apb_write(`CLK_REG_STATUS, 32'hFFFF_FFFF, 1'b1);
        apb_read(`CLK_REG_CTRL, rd, 1'b0);
        check_value("CTRL after faulted writes", rd, 32'h20, 0);
        apb_read(`CLK_REG_DIV, rd, 1'b0);
        check_value("DIV after faulted writes", rd, 1, 0);
        apb_write(`CLK_REG_CTRL, ctrl_word(clk_pkg::SRC_REF, 1'b1, 1'b1), 1'b0);
    endtask

    task automatic divider_lock_rate();
        logic [31:0] rd;
        int          ratio;
        repeat (3) begin
            ratio = int'($urandom % ((1 << `CLK_DIV_W) - 1)) + 1;
            apb_write(`CLK_REG_DIV, ratio, 1'b0);
            apb_read(`CLK_REG_DIV, rd, 1'b0);
            check_value("DIV random ratio", rd, ratio, 0);
            wait_lock();
            switch_and_measure(clk_pkg::SRC_DIV, ratio);
        end
    endtask

    task automatic source_cycle();
        apb_write(`CLK_REG_DIV, 32'd3, 1'b0);
        wait_lock();
        switch_and_measure(clk_pkg::SRC_REF, 3);
        switch_and_measure(clk_pkg::SRC_OFF, 3);
        switch_and_measure(clk_pkg::SRC_DIV, 3);
        switch_and_measure(clk_pkg::SRC_REF, 3);
    endtask

    task automatic gate_enables();
        int edges;
        apb_write(`CLK_REG_CTRL, ctrl_word(clk_pkg::SRC_REF, 1'b0, 1'b1), 1'b0);
        repeat (GATE_SETTLE) @(negedge ref_clk);
        count_edges(1'b0, edges);
        check_value("sys_clk edges, gate closed", edges, 0, 0);
        count_edges(1'b1, edges);
        check_value("off_clk_gated edges, gate open", edges,
                    expected_edges(clk_pkg::SRC_OFF, 1), 1);
        apb_write(`CLK_REG_CTRL, ctrl_word(clk_pkg::SRC_REF, 1'b1, 1'b0), 1'b0);
        repeat (GATE_SETTLE) @(negedge ref_clk);
        count_edges(1'b0, edges);
        check_value("sys_clk edges, gate reopened", edges, WINDOW, 1);
        count_edges(1'b1, edges);
        check_value("off_clk_gated edges, gate closed", edges, 0, 0);
        apb_write(`CLK_REG_CTRL, ctrl_word(clk_pkg::SRC_REF, 1'b1, 1'b1), 1'b0);
        repeat (GATE_SETTLE) @(negedge ref_clk);
        count_edges(1'b1, edges);
        check_value("off_clk_gated edges, gate reopened", edges,
                    expected_edges(clk_pkg::SRC_OFF, 1), 1);
    endtask

    // Second request lands while the first switch is running
    task automatic queued_request();
        logic [31:0] st;
        int          edges;
        apb_write(`CLK_REG_DIV, 32'd31, 1'b0);
        wait_lock();
        apb_write(`CLK_REG_CTRL, ctrl_word(clk_pkg::SRC_OFF, 1'b1, 1'b1), 1'b0);
        apb_read(`CLK_REG_STATUS, st, 1'b0);
        check_value("STATUS busy during switch", st[8], 1, 0);
        apb_write(`CLK_REG_CTRL, ctrl_word(clk_pkg::SRC_DIV, 1'b1, 1'b1), 1'b0);
        wait_not_busy(clk_pkg::SRC_DIV);
        apb_read(`CLK_REG_STATUS, st, 1'b0);
        check_value("STATUS active after queued request", st[5:4], clk_pkg::SRC_DIV, 0);
        check_value("STATUS busy after queued request", st[8], 0, 0);
        count_edges(1'b0, edges);
        check_value("sys_clk edges after queued request", edges,
                    expected_edges(clk_pkg::SRC_DIV, 31), 1);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(SEED));
        ref_clk = 1'b0;
        off_clk = 1'b0;
        rst     = 1'b1;
        apb_req = '0;
        repeat (4) @(negedge ref_clk);
        rst = 1'b0;
        repeat (2) @(negedge ref_clk);
        mon_on = 1'b1;

        register_access();
        divider_lock_rate();
        source_cycle();
        gate_enables();
        queued_request();

        check_value("short sys_clk phases", sys_short, 0, 0);
        check_value("short off_clk_gated phases", off_short, 0, 0);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+rtl
rtl/clk_pkg.sv
rtl/clk_apb_regs.sv
rtl/clk_div_gen.sv
rtl/clk_src_mux.sv
rtl/clk_release_gate.sv
rtl/clk_ctrl_top.sv
test/tb_clk_ctrl.sv

/* Bender.yml */
package:
  name: clk_ctrl

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/clk_pkg.sv
      - rtl/clk_apb_regs.sv
      - rtl/clk_div_gen.sv
      - rtl/clk_src_mux.sv
      - rtl/clk_release_gate.sv
      - rtl/clk_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clk_ctrl.sv
